// ==== Makefile ====
TOP = tb_mul_unit

sim:
	verilator --binary --timing --assert -f files.f --top-module $(TOP) -Mdir obj_dir
	./obj_dir/V$(TOP) | tee sim.log
	grep -q "Simulation PASSED" sim.log

clean:
	rm -rf obj_dir sim.log

.PHONY: sim clean

// ==== files.f ====
+incdir+verilog
verilog/rv32i_types.sv
verilog/shift_add_multiplier.sv
verilog/mul_rs.sv
verilog/mul_unit.sv
testbench/tb_clock.sv
testbench/tb_mul_unit.sv

// ==== testbench/tb_clock.sv ====
module tb_clock (
  output logic clk
);

  // period of 8 time units
  initial begin
    clk = 1'b0;
  end

  always begin
    #4 clk = ~clk;
  end

endmodule

// ==== testbench/tb_mul_unit.sv ====
`include "mul_config.svh"

module tb_mul_unit;
  import rv32i_types::*;

  localparam int reset_cycles = 10;
  localparam int num_fixed = 12;
  localparam int num_random = 4;
  localparam int num_burst = 8;
  localparam int burst_first = num_fixed + num_random;
  localparam int num_rows = burst_first + num_burst;
  localparam int num_tags = 1 << `ROB_DEPTH;
  localparam int watchdog_cycles = reset_cycles + num_rows * 40 + 500;

  // where an operand comes from at issue
  localparam logic [1:0] src_rf = 2'd0;
  localparam logic [1:0] src_rob = 2'd1;
  localparam logic [1:0] src_cdb = 2'd2;

  typedef struct packed {
    logic [2:0]  funct3;
    logic [31:0] a;
    logic [31:0] b;
    rob_tag_t    tag;
    rob_tag_t    rs1_tag;
    rob_tag_t    rs2_tag;
    logic [1:0]  src1;
    logic [1:0]  src2;
    logic [3:0]  delay;
    logic        lane;
    logic [31:0] expected;
  } test_row_t;

  logic        clk;
  logic        rst;
  logic        issue;
  mul_issue_t  issue_data;
  cdb_entry_t  cdb [`CDB_SIZE];
  logic        full;
  logic        result_valid;
  mul_result_t result;

  test_row_t table_rows [num_rows];
  string     row_names [num_rows];

  // outstanding multiplies by target tag
  logic [num_tags-1:0] pending;
  logic [31:0]         pending_value [num_tags];
  string               pending_name [num_tags];

  int value_errors;
  int other_errors;
  int issued;
  int pulses = 0;
  int seed;

  tb_clock clock_gen (
    .clk (clk)
  );

  mul_unit uut (
    .clk          (clk),
    .rst          (rst),
    .issue        (issue),
    .issue_data   (issue_data),
    .cdb          (cdb),
    .full         (full),
    .result_valid (result_valid),
    .result       (result)
  );

  // result word of a RISC-V M extension multiply
  function automatic logic [31:0] model_multiply(logic [2:0] funct3, logic [31:0] a,
                                                 logic [31:0] b);
    logic signed [63:0] sa;
    logic signed [63:0] sb;
    logic [63:0]        ua;
    logic [63:0]        ub;
    logic [63:0]        prod;
    sa = {{32{a[31]}}, a};
    sb = {{32{b[31]}}, b};
    ua = {32'd0, a};
    ub = {32'd0, b};
    case (mul_funct3_t'(funct3))
      funct3_mulh:   prod = sa * sb;
      funct3_mulhsu: prod = sa * $signed(ub);
      default:       prod = ua * ub;
    endcase
    if (mul_funct3_t'(funct3) == funct3_mul) begin
      return prod[31:0];
    end
    return prod[63:32];
  endfunction

  // the losing source always carries a wrong value
  function automatic operand_src_t source_for(logic [1:0] mode, logic [1:0] slot,
                                              logic [31:0] value);
    operand_src_t src;
    if (slot == src_rf) begin
      src.ready = (mode == src_rf);
      src.value = (mode == src_rf) ? value : value ^ 32'h5a5a_5a5a;
    end else begin
      src.ready = (mode != src_cdb);
      src.value = (mode == src_rob) ? value : ~value;
    end
    return src;
  endfunction

  function automatic mul_issue_t make_issue(test_row_t row);
    mul_issue_t pkt;
    pkt.funct3      = row.funct3;
    pkt.target_tag  = row.tag;
    pkt.rs1_tag     = row.rs1_tag;
    pkt.rs2_tag     = row.rs2_tag;
    pkt.rs1_regfile = source_for(row.src1, src_rf, row.a);
    pkt.rs2_regfile = source_for(row.src2, src_rf, row.b);
    pkt.rs1_rob     = source_for(row.src1, src_rob, row.a);
    pkt.rs2_rob     = source_for(row.src2, src_rob, row.b);
    return pkt;
  endfunction

  task automatic set_row(input int idx, input string name, input logic [2:0] funct3,
                         input logic [31:0] a, input logic [31:0] b, input logic [1:0] src1,
                         input logic [1:0] src2, input int delay, input int lane);
    row_names[idx]           = name;
    table_rows[idx].funct3   = funct3;
    table_rows[idx].a        = a;
    table_rows[idx].b        = b;
    table_rows[idx].tag      = rob_tag_t'(idx % num_tags);
    table_rows[idx].rs1_tag  = table_rows[idx].tag ^ rob_tag_t'(1);
    table_rows[idx].rs2_tag  = table_rows[idx].tag ^ rob_tag_t'(2);
    table_rows[idx].src1     = src1;
    table_rows[idx].src2     = src2;
    table_rows[idx].delay    = 4'(delay);
    table_rows[idx].lane     = 1'(lane);
    table_rows[idx].expected = model_multiply(funct3, a, b);
  endtask

  task automatic build_table();
    set_row(0, "mul_small", funct3_mul, 32'd7, 32'd6, src_rf, src_rf, 0, 0);
    set_row(1, "mul_neg", funct3_mul, 32'hffff_fffd, 32'd5, src_rf, src_rf, 0, 0);
    set_row(2, "mulh_min_min", funct3_mulh, 32'h8000_0000, 32'h8000_0000, src_rf, src_rf, 0, 0);
    set_row(3, "mulh_neg_pos", funct3_mulh, 32'hffff_fffe, 32'd3, src_rf, src_rf, 0, 0);
    set_row(4, "mulhsu_neg", funct3_mulhsu, 32'hffff_ffff, 32'hffff_ffff, src_rf, src_rf, 0, 0);
    set_row(5, "mulhsu_min", funct3_mulhsu, 32'h8000_0000, 32'hffff_ffff, src_rf, src_rf, 0, 0);
    set_row(6, "mulhu_max", funct3_mulhu, 32'hffff_ffff, 32'hffff_ffff, src_rf, src_rf, 0, 0);
    set_row(7, "rob_rs1", funct3_mul, 32'h1234_5678, 32'h10, src_rob, src_rf, 0, 0);
    set_row(8, "rob_both", funct3_mulh, 32'hdead_beef, 32'h7fff_ffff, src_rob, src_rob, 0, 0);
    set_row(9, "cdb_rs1_lane0", funct3_mul, 32'd100, 32'hffff_fff9, src_cdb, src_rf, 2, 0);
    set_row(10, "cdb_rs2_lane1", funct3_mulhu, 32'h9abc_def0, 32'h1234_5678,
            src_rf, src_cdb, 1, 1);
    set_row(11, "cdb_both", funct3_mulhsu, 32'h8765_4321, 32'hfedc_ba98,
            src_cdb, src_cdb, 3, 1);
    for (int k = 0; k < num_random; k++) begin
      set_row(num_fixed + k, $sformatf("random_%0d", k), 3'(k % 4), $random(seed),
              $random(seed), (k % 2 == 0) ? src_rf : src_rob, (k < 2) ? src_rob : src_cdb,
              k, k % 2);
    end
    // each burst entry waits on its own tag
    for (int k = 0; k < num_burst; k++) begin
      set_row(burst_first + k, $sformatf("burst_%0d", k), 3'(k % 4), $random(seed),
              $random(seed), (k % 2 == 0) ? src_cdb : src_rob,
              (k % 2 == 0) ? src_rf : src_cdb, 0, 0);
      table_rows[burst_first + k].rs1_tag = rob_tag_t'(k);
      table_rows[burst_first + k].rs2_tag = rob_tag_t'(k);
    end
  endtask

  task automatic check_result(input string name, input mul_result_t expected,
                              input mul_result_t actual);
    if (actual !== expected) begin
      value_errors++;
      $display("Fail %s: expected tag %0d value %08h, actual tag %0d value %08h",
               name, expected.tag, expected.value, actual.tag, actual.value);
    end
  endtask

  task automatic check_flag(input string name, input logic expected, input logic actual);
    if (actual !== expected) begin
      value_errors++;
      $display("Fail %s: expected %0b, actual %0b", name, expected, actual);
    end
  endtask

  task automatic clear_cdb();
    for (int j = 0; j < `CDB_SIZE; j++) begin
      cdb[j] = '0;
    end
  endtask

  // called and returns on a falling edge
  task automatic issue_row(input int idx);
    if (full) begin
      other_errors++;
      $display("station full, could not issue %s", row_names[idx]);
    end else begin
      issue                            = 1'b1;
      issue_data                       = make_issue(table_rows[idx]);
      pending[table_rows[idx].tag]       = 1'b1;
      pending_value[table_rows[idx].tag] = table_rows[idx].expected;
      pending_name[table_rows[idx].tag]  = row_names[idx];
      issued++;
      @(negedge clk);
      issue = 1'b0;
    end
  endtask

  task automatic release_operands(input int idx);
    test_row_t row;
    int        lane_a;
    int        lane_b;
    row    = table_rows[idx];
    lane_a = int'(row.lane);
    lane_b = 1 - lane_a;
    if (row.src1 == src_cdb || row.src2 == src_cdb) begin
      repeat (row.delay) @(negedge clk);
      // right tag with valid low, then a tag nobody waits on
      cdb[lane_a] = '{valid: 1'b0, tag: (row.src1 == src_cdb) ? row.rs1_tag : row.rs2_tag,
                      value: 32'hbad0_0001};
      cdb[lane_b] = '{valid: 1'b1, tag: row.tag ^ rob_tag_t'(4), value: 32'hbad0_0002};
      @(negedge clk);
      clear_cdb();
      if (row.src1 == src_cdb) begin
        cdb[lane_a] = '{valid: 1'b1, tag: row.rs1_tag, value: row.a};
      end
      if (row.src2 == src_cdb) begin
        cdb[(row.src1 == src_cdb) ? lane_b : lane_a] =
          '{valid: 1'b1, tag: row.rs2_tag, value: row.b};
      end
      @(negedge clk);
      clear_cdb();
    end
  endtask

  task automatic collect_results(input int count);
    int          got;
    int          cycles;
    mul_result_t want;
    got    = 0;
    cycles = 0;
    while (got < count && cycles < 40 * count + 20) begin
      @(negedge clk);
      cycles++;
      if (result_valid) begin
        if (!pending[result.tag]) begin
          other_errors++;
          $display("result with tag %0d arrived but nothing was outstanding", result.tag);
        end else begin
          want = '{tag: result.tag, value: pending_value[result.tag]};
          check_result(pending_name[result.tag], want, result);
          pending[result.tag] = 1'b0;
          got++;
        end
      end
    end
    for (int t = 0; t < num_tags; t++) begin
      if (pending[t]) begin
        other_errors++;
        $display("no result arrived for tag %0d (%s)", t, pending_name[t]);
        pending[t] = 1'b0;
      end
    end
  endtask

  always @(negedge clk) begin
    if (!rst && result_valid) begin
      pulses++;
    end
  end

  initial begin
    repeat (watchdog_cycles) @(posedge clk);
    $display("watchdog expired after %0d cycles, run did not complete", watchdog_cycles);
    $display("Simulation FAILED");
    $finish;
  end

  initial begin
    seed         = 32'h0146_e40b;
    rst          = 1'b1;
    issue        = 1'b0;
    issue_data   = '0;
    pending      = '0;
    value_errors = 0;
    other_errors = 0;
    issued       = 0;
    clear_cdb();
    build_table();
    repeat (reset_cycles) @(posedge clk);
    @(negedge clk);
    rst = 1'b0;
    check_flag("result_valid after reset", 1'b0, result_valid);
    check_flag("full after reset", 1'b0, full);

    // one multiply at a time
    for (int i = 0; i < burst_first; i++) begin
      issue_row(i);
      release_operands(i);
      collect_results(1);
    end

    // eight waiting entries fill the station
    for (int i = burst_first; i < num_rows; i++) begin
      check_flag("full during burst", 1'b0, full);
      issue_row(i);
    end
    check_flag("full after eight issues", 1'b1, full);
    for (int k = 0; k < num_burst; k += 2) begin
      for (int j = 0; j < 2; j++) begin
        cdb[j] = '{valid: 1'b1, tag: rob_tag_t'(k + j),
                   value: (table_rows[burst_first + k + j].src1 == src_cdb) ?
                          table_rows[burst_first + k + j].a :
                          table_rows[burst_first + k + j].b};
      end
      @(negedge clk);
    end
    clear_cdb();
    collect_results(num_burst);
    check_flag("full after drain", 1'b0, full);

    repeat (5) @(negedge clk);
    if (pulses != issued) begin
      other_errors++;
      $display("saw %0d result pulses for %0d issued multiplies", pulses, issued);
    end
    $display("errors: %0d wrong values, %0d other failures", value_errors, other_errors);
    if (value_errors == 0 && other_errors == 0) begin
      $display("Simulation PASSED");
    end else begin
      $display("Simulation FAILED");
    end
    $finish;
  end

endmodule

// ==== verilog/mul_config.svh ====
`ifndef MUL_CONFIG_SVH
`define MUL_CONFIG_SVH

// log2 of the reservation station entry count
`define MUL_RS_DEPTH 3

// rob tag width in bits
`define ROB_DEPTH 3

// number of result buses snooped by the station
`define CDB_SIZE 2

`endif

// ==== verilog/mul_rs.sv ====
`include "mul_config.svh"

module mul_rs (
  input  logic                     clk,
  input  logic                     rst,
  input  logic                     issue,
  input  rv32i_types::mul_issue_t  issue_data,
  input  rv32i_types::cdb_entry_t  cdb [`CDB_SIZE],
  output logic                     full,
  output logic                     result_valid,
  output rv32i_types::mul_result_t result
);
  import rv32i_types::*;

  localparam int num_entries = 2 ** `MUL_RS_DEPTH;

  typedef logic [`MUL_RS_DEPTH-1:0] rs_index_t;

  // per-entry payload without the ready bits
  typedef struct packed {
    logic [2:0]  funct3;
    rob_tag_t    target_tag;
    rob_tag_t    rs1_tag;
    rob_tag_t    rs2_tag;
    logic [31:0] rs1_value;
    logic [31:0] rs2_value;
  } rs_entry_t;

  rs_entry_t entries [num_entries];

  logic [num_entries-1:0] occupied;
  logic [num_entries-1:0] executing;
  logic [num_entries-1:0] rs1_ready;
  logic [num_entries-1:0] rs2_ready;
  logic [num_entries-1:0] ready_vec;

  rs_index_t rr_ptr;
  rs_index_t exec_index;
  rs_index_t free_index;
  rs_index_t sel_index;
  logic      sel_found;

  // cdb matches for waiting operands and for the incoming issue
  operand_src_t snoop1 [num_entries];
  operand_src_t snoop2 [num_entries];
  operand_src_t rs1_fwd;
  operand_src_t rs2_fwd;
  operand_src_t issue_rs1;
  operand_src_t issue_rs2;

  // multiplier interface
  logic        mul_start;
  logic        mul_idle;
  mul_type_t   mul_type;
  logic [31:0] mul_a;
  logic [31:0] mul_b;
  logic [63:0] mul_p;
  logic        mul_busy;
  logic        mul_done;
  logic [2:0]  sel_funct3;

  // regfile first, then rob, then whatever the cdb shows this cycle
  function automatic operand_src_t pick_operand(operand_src_t regfile,
                                                operand_src_t rob,
                                                operand_src_t fwd);
    if (regfile.ready) begin
      return regfile;
    end else if (rob.ready) begin
      return rob;
    end
    return fwd;
  endfunction

  always_comb begin
    rs1_fwd = '0;
    rs2_fwd = '0;
    for (int i = 0; i < num_entries; i++) begin
      snoop1[i] = '0;
      snoop2[i] = '0;
    end
    for (int j = 0; j < `CDB_SIZE; j++) begin
      if (cdb[j].valid) begin
        if (cdb[j].tag == issue_data.rs1_tag) begin
          rs1_fwd = '{ready: 1'b1, value: cdb[j].value};
        end
        if (cdb[j].tag == issue_data.rs2_tag) begin
          rs2_fwd = '{ready: 1'b1, value: cdb[j].value};
        end
        for (int i = 0; i < num_entries; i++) begin
          if (cdb[j].tag == entries[i].rs1_tag) begin
            snoop1[i] = '{ready: 1'b1, value: cdb[j].value};
          end
          if (cdb[j].tag == entries[i].rs2_tag) begin
            snoop2[i] = '{ready: 1'b1, value: cdb[j].value};
          end
        end
      end
    end
  end

  assign issue_rs1 = pick_operand(issue_data.rs1_regfile, issue_data.rs1_rob, rs1_fwd);
  assign issue_rs2 = pick_operand(issue_data.rs2_regfile, issue_data.rs2_rob, rs2_fwd);

  // lowest free slot takes the next issue
  always_comb begin
    free_index = '0;
    for (int i = num_entries - 1; i >= 0; i--) begin
      if (!occupied[i]) begin
        free_index = rs_index_t'(i);
      end
    end
  end

  assign full = &occupied;

  assign ready_vec = occupied & rs1_ready & rs2_ready & ~executing;

  // first ready entry at or after the rotating pointer
  always_comb begin
    rs_index_t idx;
    sel_found = 1'b0;
    sel_index = rr_ptr;
    for (int k = 0; k < num_entries; k++) begin
      idx = rr_ptr + rs_index_t'(k);
      if (!sel_found && ready_vec[idx]) begin
        sel_found = 1'b1;
        sel_index = idx;
      end
    end
  end

  assign mul_idle  = !mul_busy && !mul_done;
  assign mul_start = sel_found && mul_idle;

  assign sel_funct3 = entries[sel_index].funct3;
  assign mul_a      = entries[sel_index].rs1_value;
  assign mul_b      = entries[sel_index].rs2_value;

  // MUL takes the low word where signedness does not matter
  always_comb begin
    case (mul_funct3_t'(sel_funct3))
      funct3_mulh:   mul_type = mul_ss;
      funct3_mulhsu: mul_type = mul_su;
      default:       mul_type = mul_uu;
    endcase
  end

  // control state
  always_ff @(posedge clk) begin
    if (rst) begin
      occupied     <= '0;
      executing    <= '0;
      rs1_ready    <= '0;
      rs2_ready    <= '0;
      rr_ptr       <= '0;
      exec_index   <= '0;
      result_valid <= 1'b0;
    end else begin
      result_valid <= mul_done;
      for (int i = 0; i < num_entries; i++) begin
        if (occupied[i] && !rs1_ready[i] && snoop1[i].ready) begin
          rs1_ready[i] <= 1'b1;
        end
        if (occupied[i] && !rs2_ready[i] && snoop2[i].ready) begin
          rs2_ready[i] <= 1'b1;
        end
      end
      if (issue && !full) begin
        occupied[free_index]  <= 1'b1;
        rs1_ready[free_index] <= issue_rs1.ready;
        rs2_ready[free_index] <= issue_rs2.ready;
      end
      if (mul_start) begin
        executing[sel_index] <= 1'b1;
        exec_index           <= sel_index;
      end
      // pop on the done edge while the result goes out next cycle
      if (mul_done) begin
        occupied[exec_index]  <= 1'b0;
        executing[exec_index] <= 1'b0;
        rs1_ready[exec_index] <= 1'b0;
        rs2_ready[exec_index] <= 1'b0;
        rr_ptr                <= rr_ptr + rs_index_t'(1);
      end
    end
  end

  // payload
  always_ff @(posedge clk) begin
    for (int i = 0; i < num_entries; i++) begin
      if (occupied[i] && !rs1_ready[i] && snoop1[i].ready) begin
        entries[i].rs1_value <= snoop1[i].value;
      end
      if (occupied[i] && !rs2_ready[i] && snoop2[i].ready) begin
        entries[i].rs2_value <= snoop2[i].value;
      end
    end
    if (issue && !full) begin
      entries[free_index] <= '{
        funct3:     issue_data.funct3,
        target_tag: issue_data.target_tag,
        rs1_tag:    issue_data.rs1_tag,
        rs2_tag:    issue_data.rs2_tag,
        rs1_value:  issue_rs1.value,
        rs2_value:  issue_rs2.value
      };
    end
    if (mul_done) begin
      result.tag   <= entries[exec_index].target_tag;
      result.value <= (mul_funct3_t'(entries[exec_index].funct3) == funct3_mul) ?
                      mul_p[31:0] : mul_p[63:32];
    end
  end

  shift_add_multiplier multiplier (
    .clk      (clk),
    .rst      (rst),
    .start    (mul_start),
    .mul_type (mul_type),
    .a        (mul_a),
    .b        (mul_b),
    .p        (mul_p),
    .busy     (mul_busy),
    .done     (mul_done)
  );

  // dispatcher has to respect full
  issue_when_full: assert property (
    @(posedge clk) disable iff (rst) issue |-> !full
  );

  single_executing: assert property (
    @(posedge clk) disable iff (rst) $onehot0(executing)
  );

endmodule

// ==== verilog/mul_unit.sv ====
`include "mul_config.svh"

module mul_unit (
  input  logic                     clk,
  input  logic                     rst,
  input  logic                     issue,
  input  rv32i_types::mul_issue_t  issue_data,
  input  rv32i_types::cdb_entry_t  cdb [`CDB_SIZE],
  output logic                     full,
  output logic                     result_valid,
  output rv32i_types::mul_result_t result
);
  import rv32i_types::*;

  // one station feeding one iterative multiplier
  mul_rs rs (
    .clk          (clk),
    .rst          (rst),
    .issue        (issue),
    .issue_data   (issue_data),
    .cdb          (cdb),
    .full         (full),
    .result_valid (result_valid),
    .result       (result)
  );

endmodule

// ==== verilog/rv32i_types.sv ====
`include "mul_config.svh"

package rv32i_types;

  // rob index
  typedef logic [`ROB_DEPTH-1:0] rob_tag_t;

  // one candidate source for an operand
  typedef struct packed {
    logic        ready;
    logic [31:0] value;
  } operand_src_t;

  // everything the dispatcher hands over for one multiply
  typedef struct packed {
    logic [2:0]   funct3;
    rob_tag_t     target_tag;
    rob_tag_t     rs1_tag;
    rob_tag_t     rs2_tag;
    operand_src_t rs1_regfile;
    operand_src_t rs2_regfile;
    operand_src_t rs1_rob;
    operand_src_t rs2_rob;
  } mul_issue_t;

  // one common data bus lane
  typedef struct packed {
    logic        valid;
    rob_tag_t    tag;
    logic [31:0] value;
  } cdb_entry_t;

  // broadcast payload of the multiply unit
  typedef struct packed {
    rob_tag_t    tag;
    logic [31:0] value;
  } mul_result_t;

  // operand signedness seen by the multiplier
  typedef enum logic [1:0] {
    mul_uu = 2'b00,
    mul_ss = 2'b01,
    mul_su = 2'b10
  } mul_type_t;

  // M extension multiply codes
  typedef enum logic [2:0] {
    funct3_mul    = 3'b000,
    funct3_mulh   = 3'b001,
    funct3_mulhsu = 3'b010,
    funct3_mulhu  = 3'b011
  } mul_funct3_t;

endpackage

// ==== verilog/shift_add_multiplier.sv ====
module shift_add_multiplier (
  input  logic                   clk,
  input  logic                   rst,
  input  logic                   start,
  input  rv32i_types::mul_type_t mul_type,
  input  logic [31:0]            a,
  input  logic [31:0]            b,
  output logic [63:0]            p,
  output logic                   busy,
  output logic                   done
);
  import rv32i_types::*;

  // multiplicand shifts left and multiplier shifts right
  logic [63:0] mcand;
  logic [31:0] mplier;
  logic [63:0] acc;
  logic [63:0] acc_next;
  logic        negate;
  logic [4:0]  step;
  logic        last_step;

  // magnitudes and result sign for the incoming pair
  logic [31:0] mag_a;
  logic [31:0] mag_b;
  logic        neg_next;

  always_comb begin
    mag_a    = a;
    mag_b    = b;
    neg_next = 1'b0;
    case (mul_type)
      mul_ss: begin
        mag_a    = a[31] ? -a : a;
        mag_b    = b[31] ? -b : b;
        neg_next = a[31] ^ b[31];
      end
      mul_su: begin
        // only a carries a sign
        mag_a    = a[31] ? -a : a;
        neg_next = a[31];
      end
      default: begin
        mag_a    = a;
        mag_b    = b;
        neg_next = 1'b0;
      end
    endcase
  end

  assign acc_next  = acc + (mplier[0] ? mcand : 64'd0);
  assign last_step = (step == 5'd31);

  // step counter and status
  always_ff @(posedge clk) begin
    if (rst) begin
      busy <= 1'b0;
      done <= 1'b0;
      step <= '0;
    end else begin
      done <= 1'b0;
      if (start) begin
        busy <= 1'b1;
        step <= '0;
      end else if (busy) begin
        step <= step + 5'd1;
        if (last_step) begin
          busy <= 1'b0;
          done <= 1'b1;
        end
      end
    end
  end

  // datapath
  always_ff @(posedge clk) begin
    if (start) begin
      mcand  <= {32'd0, mag_a};
      mplier <= mag_b;
      acc    <= '0;
      negate <= neg_next;
    end else if (busy) begin
      mcand  <= mcand << 1;
      mplier <= mplier >> 1;
      acc    <= acc_next;
      // sign fix folded into the last add
      if (last_step) begin
        p <= negate ? -acc_next : acc_next;
      end
    end
  end

  // the station must wait until the previous product is out
  start_while_busy: assert property (
    @(posedge clk) disable iff (rst) start |-> !busy && !done
  );

  // product is ready exactly 33 cycles after start
  done_after_start: assert property (
    @(posedge clk) disable iff (rst) start |-> ##33 done
  );

endmodule
